/* tb.f */
+incdir+.
l1d_pkg.sv
l1d_tag_ram.sv
l1d_data_ram.sv
l1d_lru.sv
l1d_ctrl.sv
l1d_top.sv
tb_mau_model.sv
tb_l1d_top.sv

/* Bender.yml */
package:
  name: l1d_cache

sources:
  - include_dirs:
      - .
    files:
      - l1d_pkg.sv
      - l1d_tag_ram.sv
      - l1d_data_ram.sv
      - l1d_lru.sv
      - l1d_ctrl.sv
      - l1d_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mau_model.sv
      - tb_l1d_top.sv

/* tb_l1d_top.sv */
// ------------------------------
// Directed cases followed by 300 random requests
// Full-word writes use size code 3
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module tb_l1d_top;

	import l1d_pkg::*;

	localparam logic [31:0] FILL_KEY = 32'hA5C3_0F69;
	localparam int TIMEOUT = 200;
	localparam logic [1:0] SZ_BYTE = 2'd1;
	localparam logic [1:0] SZ_HALF = 2'd2;
	localparam logic [1:0] SZ_WORD = 2'd3;

	logic clk = 1'b0;
	logic rst_n;
	logic core_req_val;
	l1d_core_req_s core_req;
	logic core_req_ack;
	logic [`L1D_DATA_WIDTH-1:0] core_ack_data;
	logic mau_req_val;
	l1d_mau_req_s mau_req;
	logic mau_req_ack;
	logic [`L1D_LINE_WIDTH-1:0] mau_ack_data;
	int refill_cnt;

	// ------------------------------
	// Reference model state
	// ------------------------------
	logic [31:0] shadow [logic [31:0]];
	logic [`L1D_TAG_WIDTH-1:0] ref_tag [`L1D_SET_NUM][`L1D_WAY_NUM];
	logic ref_valid [`L1D_SET_NUM][`L1D_WAY_NUM];
	int ref_age [`L1D_SET_NUM][`L1D_WAY_NUM];
	logic [31:0] ref_data [`L1D_SET_NUM][`L1D_WAY_NUM][4];
	int ref_refills;

	always #4 clk = ~clk;

	l1d_top UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.core_req_val  (core_req_val),
		.core_req      (core_req),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.mau_req_val   (mau_req_val),
		.mau_req       (mau_req),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data)
	);

	tb_mau_model #(.FILL_KEY(FILL_KEY)) u_mau (
		.clk          (clk),
		.rst_n        (rst_n),
		.mau_req_val  (mau_req_val),
		.mau_req      (mau_req),
		.mau_req_ack  (mau_req_ack),
		.mau_ack_data (mau_ack_data),
		.refill_cnt   (refill_cnt)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else abort_run($sformatf("FAIL at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] wa;
		wa = {addr[31:2], 2'b00};
		return shadow.exists(wa) ? shadow[wa] : (wa ^ FILL_KEY);
	endfunction

	// Low size bytes of the word
	function automatic logic [3:0] size_be(input logic [1:0] size);
		return (size == SZ_BYTE) ? 4'b0001 : ((size == SZ_HALF) ? 4'b0011 : 4'b1111);
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
			input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				res[b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		return res;
	endfunction

	function automatic int find_hit(input int idx, input logic [`L1D_TAG_WIDTH-1:0] tag);
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Lowest invalid way first, else the oldest
	function automatic int pick_victim(input int idx);
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			if (!ref_valid[idx][w]) begin
				return w;
			end
		end
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			if (ref_age[idx][w] == `L1D_WAY_NUM - 1) begin
				return w;
			end
		end
		return 0;
	endfunction

	function automatic void touch(input int idx, input int way);
		int old_age;
		old_age = ref_age[idx][way];
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			if (w == way) begin
				ref_age[idx][w] = 0;
			end else if (ref_age[idx][w] < old_age) begin
				ref_age[idx][w]++;
			end
		end
	endfunction

	// ------------------------------
	// One core request, checked end to end
	// ------------------------------
	task automatic do_req(input l1d_cop_e cop, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [1:0] size);
		int idx;
		int wsel;
		int way;
		int mau_cnt;
		int cycles;
		bit got_ack;
		logic [`L1D_TAG_WIDTH-1:0] tag;
		logic [31:0] exp_data;
		logic [31:0] exp_addr;
		logic [3:0] be;
		logic exp_nc;
		logic exp_we;
		int exp_mau;

		idx = addr[9:4];
		wsel = addr[3:2];
		tag = addr[31:10];
		be = size_be(size);
		way = find_hit(idx, tag);
		exp_nc = (cop == RDNC) || (cop == WRNC);
		exp_we = (cop == WR) || (cop == WRNC);
		exp_addr = addr;
		exp_mau = 1;
		exp_data = mem_word(addr);
		if (cop == RD && way >= 0) begin
			exp_data = ref_data[idx][way][wsel];
			exp_mau = 0;
		end else if (cop == RD) begin
			exp_addr = {addr[31:4], 4'h0};
		end

		@(negedge clk);
		core_req_val = 1'b1;
		core_req.cop = cop;
		core_req.addr.word = addr;
		core_req.wdata = wdata;
		core_req.size = size;
		mau_cnt = 0;
		cycles = 0;
		got_ack = 1'b0;
		while (!got_ack) begin
			@(posedge clk);
			if (mau_req_val && mau_req_ack) begin
				mau_cnt++;
				check_val("mau_req.nc", mau_req.nc, exp_nc);
				check_val("mau_req.we", mau_req.we, exp_we);
				check_val("mau_req.addr", mau_req.addr, exp_addr);
				if (exp_we) begin
					check_val("mau_req.wdata", mau_req.wdata, wdata);
					check_val("mau_req.be", mau_req.be, be);
				end
			end
			if (core_req_ack) begin
				got_ack = 1'b1;
				if (!exp_we) begin
					check_val("core_ack_data", core_ack_data, exp_data);
				end
			end else begin
				cycles++;
				if (cycles > TIMEOUT) begin
					abort_run($sformatf("No core_req_ack for request at %h within timeout", addr));
				end
			end
		end
		@(negedge clk);
		core_req_val = 1'b0;
		check_val("MAU request count", mau_cnt, exp_mau);

		// Model update
		if (cop == RD) begin
			if (way < 0) begin
				way = pick_victim(idx);
				ref_tag[idx][way] = tag;
				ref_valid[idx][way] = 1'b1;
				for (int i = 0; i < 4; i++) begin
					ref_data[idx][way][i] = mem_word({addr[31:4], 4'h0} + 32'(4 * i));
				end
				ref_refills++;
			end
			touch(idx, way);
		end else if (exp_we) begin
			shadow[{addr[31:2], 2'b00}] = merge_bytes(mem_word(addr), wdata, be);
			// Write hit merges bytes and leaves the LRU order alone
			if (cop == WR && way >= 0) begin
				ref_data[idx][way][wsel] = merge_bytes(ref_data[idx][way][wsel], wdata, be);
			end
		end
		check_val("refill_cnt", refill_cnt, ref_refills);
	endtask

	initial begin
		logic [31:0] r_addr;
		l1d_cop_e r_cop;

		void'($urandom(72));
		rst_n = 1'b0;
		core_req_val = 1'b0;
		core_req = '0;
		ref_refills = 0;
		for (int s = 0; s < `L1D_SET_NUM; s++) begin
			for (int w = 0; w < `L1D_WAY_NUM; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_age[s][w] = w;
			end
		end
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// Miss then hit in one line
		do_req(RD, 32'h0000_1004, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 1);
		do_req(RD, 32'h0000_1008, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 1);

		// Write hits of every size
		do_req(WR, 32'h0000_1008, 32'h1122_33AB, SZ_BYTE);
		do_req(RD, 32'h0000_1008, '0, SZ_WORD);
		do_req(WR, 32'h0000_100C, 32'hCAFE_BEEF, SZ_HALF);
		do_req(WR, 32'h0000_1000, 32'h0BAD_F00D, SZ_WORD);
		do_req(RD, 32'h0000_100C, '0, SZ_WORD);
		do_req(RD, 32'h0000_1000, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 1);

		// Write miss allocates nothing
		do_req(WR, 32'h0000_2040, 32'h7788_99AA, SZ_HALF);
		check_val("refill_cnt", refill_cnt, 1);
		do_req(RD, 32'h0000_2040, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 2);

		// Bypass leaves the arrays alone
		do_req(RDNC, 32'h0000_3000, '0, SZ_WORD);
		do_req(WRNC, 32'h0000_3004, 32'h5566_7788, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 2);
		do_req(RD, 32'h0000_3004, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 3);
		// Cached copy stays stale after WRNC
		do_req(WRNC, 32'h0000_1004, 32'hDEAD_0001, SZ_WORD);
		do_req(RD, 32'h0000_1004, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 3);

		// Five tags in set 5
		for (int t = 1; t <= 5; t++) begin
			do_req(RD, 32'(t * 32'h400 + 32'h50), '0, SZ_WORD);
		end
		check_val("refill_cnt", refill_cnt, 8);
		do_req(RD, 32'h0000_0450, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 9);
		do_req(RD, 32'h0000_1450, '0, SZ_WORD);
		check_val("refill_cnt", refill_cnt, 9);

		// Random mix over 8 tags and 4 sets
		repeat (300) begin
			r_addr = (($urandom % 8) << 10) | (($urandom % 4) << 4) | (($urandom % 4) << 2);
			r_cop = l1d_cop_e'($urandom % 4);
			do_req(r_cop, r_addr, $urandom, 2'($urandom % 3 + 1));
		end

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb_mau_model.sv */
// ------------------------------
// Memory behind the MAU port, each word starts as its address XOR FILL_KEY
// Ack comes 1 to 4 cycles after val, driven on the falling edge
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module tb_mau_model #(
	parameter logic [`L1D_ADDR_WIDTH-1:0] FILL_KEY = '0
) (
	input wire clk,
	input wire rst_n,
	input wire mau_req_val,
	input wire l1d_pkg::l1d_mau_req_s mau_req,
	output logic mau_req_ack,
	output logic [`L1D_LINE_WIDTH-1:0] mau_ack_data,
	output int refill_cnt
);

	import l1d_pkg::*;

	localparam int WORDS = `L1D_LINE_WIDTH / `L1D_DATA_WIDTH;

	// Sparse store, keyed by word address
	logic [`L1D_DATA_WIDTH-1:0] mem [logic [`L1D_ADDR_WIDTH-1:0]];
	logic ack_r = 1'b0;
	logic [`L1D_LINE_WIDTH-1:0] data_r = '0;
	int cnt_r = 0;
	int delay = 0;
	logic busy = 1'b0;

	assign mau_req_ack = ack_r;
	assign mau_ack_data = data_r;
	assign refill_cnt = cnt_r;

	function automatic logic [`L1D_DATA_WIDTH-1:0] read_word(input logic [31:0] addr);
		logic [31:0] wa;
		wa = {addr[31:2], 2'b00};
		if (mem.exists(wa)) begin
			return mem[wa];
		end
		return wa ^ FILL_KEY;
	endfunction

	always @(negedge clk or negedge rst_n) begin
		logic [`L1D_DATA_WIDTH-1:0] word;
		logic [`L1D_LINE_WIDTH-1:0] line;
		if (!rst_n) begin
			ack_r <= 1'b0;
			busy = 1'b0;
			delay = 0;
		end else begin
			ack_r <= 1'b0;
			if (mau_req_val && !ack_r) begin
				if (!busy) begin
					busy = 1'b1;
					delay = $urandom % 4 + 1;
				end
				delay = delay - 1;
				if (delay == 0) begin
					busy = 1'b0;
					ack_r <= 1'b1;
					if (mau_req.we) begin
						word = read_word(mau_req.addr);
						for (int b = 0; b < `L1D_BE_WIDTH; b++) begin
							if (mau_req.be[b]) begin
								word[b*8 +: 8] = mau_req.wdata[b*8 +: 8];
							end
						end
						mem[{mau_req.addr[31:2], 2'b00}] = word;
						data_r <= '0;
					end else if (mau_req.nc) begin
						data_r <= {{(`L1D_LINE_WIDTH-32){1'b0}}, read_word(mau_req.addr)};
					end else begin
						// Line read, one refill
						for (int i = 0; i < WORDS; i++) begin
							line[i*32 +: 32] = read_word(mau_req.addr + 32'(4 * i));
						end
						data_r <= line;
						cnt_r <= cnt_r + 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* l1d_top.sv */
// ------------------------------
// Write-through, no write-allocate, no flush or invalidate
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module l1d_top (
	input wire clk,
	input wire rst_n,
	input wire core_req_val,
	input wire l1d_pkg::l1d_core_req_s core_req,
	output logic core_req_ack,
	output logic [`L1D_DATA_WIDTH-1:0] core_ack_data,
	output logic mau_req_val,
	output l1d_pkg::l1d_mau_req_s mau_req,
	input wire mau_req_ack,
	input wire [`L1D_LINE_WIDTH-1:0] mau_ack_data
);

	import l1d_pkg::*;

	l1d_way_vec_t ram_en;
	l1d_way_vec_t tag_we;
	l1d_way_vec_t data_we;
	l1d_way_vec_t way_rvalid;
	l1d_way_vec_t tag_match;
	l1d_way_vec_t lru_hit_way;
	l1d_way_vec_t lru_victim;
	logic [`L1D_IDX_WIDTH-1:0] ram_idx;
	logic [`L1D_TAG_WIDTH-1:0] ram_wtag;
	logic [`L1D_LINE_WIDTH-1:0] ram_wdata;
	logic [`L1D_LINE_WIDTH/8-1:0] ram_wbe;
	logic [`L1D_WAY_NUM-1:0][`L1D_TAG_WIDTH-1:0] way_rtag;
	logic [`L1D_WAY_NUM-1:0][`L1D_LINE_WIDTH-1:0] way_rdata;
	logic lru_lookup;
	logic lru_update;
	logic lru_hit;

	l1d_ctrl u_ctrl (
		.clk           (clk),
		.rst_n         (rst_n),
		.core_req_val  (core_req_val),
		.core_req      (core_req),
		.core_req_ack  (core_req_ack),
		.core_ack_data (core_ack_data),
		.mau_req_val   (mau_req_val),
		.mau_req       (mau_req),
		.mau_req_ack   (mau_req_ack),
		.mau_ack_data  (mau_ack_data),
		.ram_en        (ram_en),
		.tag_we        (tag_we),
		.data_we       (data_we),
		.ram_idx       (ram_idx),
		.ram_wtag      (ram_wtag),
		.ram_wdata     (ram_wdata),
		.ram_wbe       (ram_wbe),
		.way_rtag      (way_rtag),
		.way_rvalid    (way_rvalid),
		.way_rdata     (way_rdata),
		.lru_lookup    (lru_lookup),
		.lru_update    (lru_update),
		.tag_match     (tag_match),
		.lru_hit       (lru_hit),
		.lru_hit_way   (lru_hit_way),
		.lru_victim    (lru_victim)
	);

	l1d_lru u_lru (
		.clk        (clk),
		.rst_n      (rst_n),
		.lookup     (lru_lookup),
		.update     (lru_update),
		.idx        (ram_idx),
		.tag_match  (tag_match),
		.valid_vec  (way_rvalid),
		.hit        (lru_hit),
		.hit_way    (lru_hit_way),
		.victim_way (lru_victim)
	);

	// ------------------------------
	// Ways
	// ------------------------------
	for (genvar w = 0; w < `L1D_WAY_NUM; w++) begin : g_way
		l1d_tag_ram u_tag (
			.clk    (clk),
			.rst_n  (rst_n),
			.en     (ram_en[w]),
			.we     (tag_we[w]),
			.idx    (ram_idx),
			.wtag   (ram_wtag),
			.rtag   (way_rtag[w]),
			.rvalid (way_rvalid[w])
		);

		l1d_data_ram u_data (
			.clk   (clk),
			.en    (ram_en[w]),
			.we    (data_we[w]),
			.idx   (ram_idx),
			.wdata (ram_wdata),
			.wbe   (ram_wbe),
			.rdata (way_rdata[w])
		);
	end

endmodule

`default_nettype wire

/* l1d_ctrl.sv */
// ------------------------------
// One request in flight, core request must be word-aligned
// Read hits are answered from the arrays, everything else waits on the MAU
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module l1d_ctrl (
	input wire clk,
	input wire rst_n,
	input wire core_req_val,
	input wire l1d_pkg::l1d_core_req_s core_req,
	output logic core_req_ack,
	output logic [`L1D_DATA_WIDTH-1:0] core_ack_data,
	output logic mau_req_val,
	output l1d_pkg::l1d_mau_req_s mau_req,
	input wire mau_req_ack,
	input wire [`L1D_LINE_WIDTH-1:0] mau_ack_data,
	output l1d_pkg::l1d_way_vec_t ram_en,
	output l1d_pkg::l1d_way_vec_t tag_we,
	output l1d_pkg::l1d_way_vec_t data_we,
	output logic [`L1D_IDX_WIDTH-1:0] ram_idx,
	output logic [`L1D_TAG_WIDTH-1:0] ram_wtag,
	output logic [`L1D_LINE_WIDTH-1:0] ram_wdata,
	output logic [`L1D_LINE_WIDTH/8-1:0] ram_wbe,
	input wire [`L1D_WAY_NUM-1:0][`L1D_TAG_WIDTH-1:0] way_rtag,
	input wire l1d_pkg::l1d_way_vec_t way_rvalid,
	input wire [`L1D_WAY_NUM-1:0][`L1D_LINE_WIDTH-1:0] way_rdata,
	output logic lru_lookup,
	output logic lru_update,
	output l1d_pkg::l1d_way_vec_t tag_match,
	input wire lru_hit,
	input wire l1d_pkg::l1d_way_vec_t lru_hit_way,
	input wire l1d_pkg::l1d_way_vec_t lru_victim
);

	import l1d_pkg::*;

	localparam int LINE_BYTES = `L1D_LINE_WIDTH / 8;
	localparam int WORDS = `L1D_LINE_WIDTH / `L1D_DATA_WIDTH;

	typedef enum logic [2:0] {IDLE, LOOKUP, COMPARE, MAU_WAIT, RESPOND} state_e;

	state_e state_r;
	state_e state_nx;
	l1d_core_req_s req_r;
	l1d_way_vec_t way_r;
	logic hit_r;
	logic [`L1D_LINE_WIDTH-1:0] line_r;
	logic [`L1D_LINE_WIDTH-1:0] hit_line;
	logic [`L1D_OFFSET_WIDTH-3:0] word_sel;
	logic [`L1D_BE_WIDTH-1:0] be;
	logic req_nc;
	logic req_rd;
	logic req_wr;
	logic read_hit;
	logic fill;
	logic merge;

	assign req_nc = (req_r.cop == RDNC) || (req_r.cop == WRNC);
	assign req_rd = (req_r.cop == RD);
	assign req_wr = (req_r.cop == WR);
	assign word_sel = req_r.addr.fld.offset[`L1D_OFFSET_WIDTH-1:2];

	assign read_hit = (state_r == COMPARE) && req_rd && lru_hit;
	// Refill of the victim, or byte merge into the hit way
	assign fill = (state_r == RESPOND) && req_rd;
	assign merge = (state_r == RESPOND) && req_wr && hit_r;

	// ------------------------------
	// FSM
	// ------------------------------
	always_comb begin
		state_nx = state_r;
		case (state_r)
			IDLE: begin
				if (core_req_val) begin
					state_nx = (core_req.cop == RDNC || core_req.cop == WRNC) ? MAU_WAIT : LOOKUP;
				end
			end
			LOOKUP: state_nx = COMPARE;
			COMPARE: state_nx = read_hit ? IDLE : MAU_WAIT;
			MAU_WAIT: begin
				if (mau_req_ack) begin
					state_nx = RESPOND;
				end
			end
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_r <= IDLE;
			hit_r <= 1'b0;
		end else begin
			state_r <= state_nx;
			if (state_r == COMPARE) begin
				hit_r <= lru_hit;
			end
		end
	end

	// Request, selected way and MAU line
	always_ff @(posedge clk) begin
		if (state_r == IDLE && core_req_val) begin
			req_r <= core_req;
		end
		if (state_r == COMPARE) begin
			way_r <= lru_hit ? lru_hit_way : lru_victim;
		end
		if (mau_req_ack) begin
			line_r <= mau_ack_data;
		end
	end

	// ------------------------------
	// Lookup
	// ------------------------------
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			tag_match[w] = way_rvalid[w] && (way_rtag[w] == req_r.addr.fld.tag);
			hit_line = hit_line | (way_rdata[w] & {`L1D_LINE_WIDTH{lru_hit_way[w]}});
		end
	end

	assign lru_lookup = (state_r == COMPARE);
	// Write hits leave the age order alone
	assign lru_update = read_hit || fill;

	// ------------------------------
	// Core response
	// ------------------------------
	assign core_req_ack = read_hit || (state_r == RESPOND);

	always_comb begin
		if (state_r == COMPARE) begin
			core_ack_data = hit_line[word_sel*`L1D_DATA_WIDTH +: `L1D_DATA_WIDTH];
		end else if (req_nc) begin
			core_ack_data = line_r[`L1D_DATA_WIDTH-1:0];
		end else begin
			core_ack_data = line_r[word_sel*`L1D_DATA_WIDTH +: `L1D_DATA_WIDTH];
		end
	end

	// ------------------------------
	// MAU request
	// ------------------------------
	always_comb begin
		case (req_r.size)
			2'd1: be = 4'b0001;
			2'd2: be = 4'b0011;
			default: be = 4'b1111;
		endcase
	end

	assign mau_req_val = (state_r == MAU_WAIT);

	always_comb begin
		mau_req.nc = req_nc;
		mau_req.we = (req_r.cop == WR) || (req_r.cop == WRNC);
		// Cacheable reads fetch the whole line
		mau_req.addr = req_rd ?
			{req_r.addr.word[`L1D_ADDR_WIDTH-1:`L1D_OFFSET_WIDTH], {`L1D_OFFSET_WIDTH{1'b0}}} :
			req_r.addr.word;
		mau_req.wdata = req_r.wdata;
		mau_req.be = be;
	end

	// ------------------------------
	// Array writes
	// ------------------------------
	assign ram_idx = req_r.addr.fld.idx;
	assign ram_wtag = req_r.addr.fld.tag;
	assign ram_wdata = fill ? line_r : {WORDS{req_r.wdata}};
	assign ram_wbe = fill ? '1 : (LINE_BYTES'(be) << {word_sel, 2'b00});

	assign ram_en = (state_r == LOOKUP) ? '1 : ((fill || merge) ? way_r : '0);
	assign tag_we = fill ? way_r : '0;
	assign data_we = (fill || merge) ? way_r : '0;

endmodule

`default_nettype wire

/* l1d_lru.sv */
// ------------------------------
// After reset way 0 is newest and way 3 oldest in every set
// update without lookup in the same cycle uses the way from the last lookup
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module l1d_lru (
	input wire clk,
	input wire rst_n,
	input wire lookup,
	input wire update,
	input wire [`L1D_IDX_WIDTH-1:0] idx,
	input wire l1d_pkg::l1d_way_vec_t tag_match,
	input wire l1d_pkg::l1d_way_vec_t valid_vec,
	output logic hit,
	output l1d_pkg::l1d_way_vec_t hit_way,
	output l1d_pkg::l1d_way_vec_t victim_way
);

	import l1d_pkg::*;

	localparam int AGE_W = $clog2(`L1D_WAY_NUM);
	localparam int AGE_MAX = `L1D_WAY_NUM - 1;

	// Age 0 is most recent, AGE_MAX least recent
	logic [`L1D_WAY_NUM-1:0][AGE_W-1:0] age_r [`L1D_SET_NUM];
	l1d_way_vec_t acc_way_r;
	l1d_way_vec_t acc_way;
	logic [AGE_W-1:0] acc_age;
	logic have_invalid;

	assign hit_way = tag_match & valid_vec;
	assign hit = |hit_way;

	// ------------------------------
	// Victim choice
	// ------------------------------
	always_comb begin
		victim_way = '0;
		have_invalid = 1'b0;
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			if (!valid_vec[w] && !have_invalid) begin
				victim_way[w] = 1'b1;
				have_invalid = 1'b1;
			end
		end
		// Set full, take the oldest
		if (!have_invalid) begin
			for (int w = 0; w < `L1D_WAY_NUM; w++) begin
				victim_way[w] = (age_r[idx][w] == AGE_W'(AGE_MAX));
			end
		end
	end

	// Way that the next update promotes
	assign acc_way = lookup ? (hit ? hit_way : victim_way) : acc_way_r;

	always_comb begin
		acc_age = '0;
		for (int w = 0; w < `L1D_WAY_NUM; w++) begin
			if (acc_way[w]) begin
				acc_age = age_r[idx][w];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (lookup) begin
			acc_way_r <= acc_way;
		end
	end

	// ------------------------------
	// Age update
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < `L1D_SET_NUM; s++) begin
				for (int w = 0; w < `L1D_WAY_NUM; w++) begin
					age_r[s][w] <= AGE_W'(w);
				end
			end
		end else if (update) begin
			// Ways younger than the accessed one age by one
			for (int w = 0; w < `L1D_WAY_NUM; w++) begin
				if (acc_way[w]) begin
					age_r[idx][w] <= '0;
				end else if (age_r[idx][w] < acc_age) begin
					age_r[idx][w] <= age_r[idx][w] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* l1d_data_ram.sv */
// ------------------------------
// Read-first line store, byte enables apply only when we is high
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module l1d_data_ram (
	input wire clk,
	input wire en,
	input wire we,
	input wire [`L1D_IDX_WIDTH-1:0] idx,
	input wire [`L1D_LINE_WIDTH-1:0] wdata,
	input wire [`L1D_LINE_WIDTH/8-1:0] wbe,
	output logic [`L1D_LINE_WIDTH-1:0] rdata
);

	localparam int LINE_BYTES = `L1D_LINE_WIDTH / 8;

	logic [`L1D_LINE_WIDTH-1:0] line_mem [`L1D_SET_NUM];

	always_ff @(posedge clk) begin
		if (en) begin
			// Refill sets every enable, a write hit only the stored bytes
			for (int b = 0; b < LINE_BYTES; b++) begin
				if (we && wbe[b]) begin
					line_mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
			rdata <= line_mem[idx];
		end
	end

endmodule

`default_nettype wire

/* l1d_tag_ram.sv */
// ------------------------------
// Read-first, the old tag and valid bit come out on a write
// Valid bits are only ever set, reset is the sole way to clear them
// ------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "l1d_defs.svh"

module l1d_tag_ram (
	input wire clk,
	input wire rst_n,
	input wire en,
	input wire we,
	input wire [`L1D_IDX_WIDTH-1:0] idx,
	input wire [`L1D_TAG_WIDTH-1:0] wtag,
	output logic [`L1D_TAG_WIDTH-1:0] rtag,
	output logic rvalid
);

	logic [`L1D_TAG_WIDTH-1:0] tag_mem [`L1D_SET_NUM];
	logic [`L1D_SET_NUM-1:0] valid_r;

	// Tag array, no reset
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				tag_mem[idx] <= wtag;
			end
			rtag <= tag_mem[idx];
		end
	end

	// Valid bits live in flops so reset can clear all sets at once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_r <= '0;
			rvalid <= 1'b0;
		end else if (en) begin
			if (we) begin
				valid_r[idx] <= 1'b1;
			end
			rvalid <= valid_r[idx];
		end
	end

endmodule

`default_nettype wire

/* l1d_pkg.sv */
// ------------------------------
// Size field: 1 and 2 give that many bytes, any other value a full word
// ------------------------------
`default_nettype none

`include "l1d_defs.svh"

package l1d_pkg;

	// Core operation codes
	typedef enum logic [1:0] {
		RD,
		WR,
		RDNC,
		WRNC
	} l1d_cop_e;

	// Address as seen by the arrays
	typedef struct packed {
		logic [`L1D_TAG_WIDTH-1:0] tag;
		logic [`L1D_IDX_WIDTH-1:0] idx;
		logic [`L1D_OFFSET_WIDTH-1:0] offset;
	} l1d_addr_fields_s;

	typedef union packed {
		logic [`L1D_ADDR_WIDTH-1:0] word;
		l1d_addr_fields_s fld;
	} l1d_addr_u;

	// ------------------------------
	// Port bundles
	// ------------------------------

	typedef struct packed {
		l1d_cop_e cop;
		l1d_addr_u addr;
		logic [`L1D_DATA_WIDTH-1:0] wdata;
		logic [`L1D_SIZE_WIDTH-1:0] size;
	} l1d_core_req_s;

	// Byte enables are word-relative
	typedef struct packed {
		logic nc;
		logic we;
		logic [`L1D_ADDR_WIDTH-1:0] addr;
		logic [`L1D_DATA_WIDTH-1:0] wdata;
		logic [`L1D_BE_WIDTH-1:0] be;
	} l1d_mau_req_s;

	// One bit per way, at most one set
	typedef logic [`L1D_WAY_NUM-1:0] l1d_way_vec_t;

endpackage

`default_nettype wire

/* l1d_defs.svh */
// ------------------------------
// Sizes for a 4-way, 64-set cache with 16-byte lines
// The offset, index and tag widths must add up to the address width
// ------------------------------
`ifndef L1D_DEFS_SVH
`define L1D_DEFS_SVH

// ------------------------------
// Core side
// ------------------------------

`define L1D_ADDR_WIDTH 32
`define L1D_DATA_WIDTH 32

// One enable per byte of the core word
`define L1D_BE_WIDTH 4

// Encoded access size, 1, 2 or 4 bytes
`define L1D_SIZE_WIDTH 2

// ------------------------------
// Cache geometry
// ------------------------------

// Full line, also the MAU ack data width
`define L1D_LINE_WIDTH 128

`define L1D_WAY_NUM 4
`define L1D_SET_NUM 64

// Address split, tag on top
`define L1D_OFFSET_WIDTH 4
`define L1D_IDX_WIDTH 6
`define L1D_TAG_WIDTH 22

`endif
